// ==== logic/flag_defs.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display raster geometry, flag of sweden geometry, colour channel width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FLAG_DEFS_SVH
`define FLAG_DEFS_SVH

`define CORDW     10       // coordinate width, covers 0..799

// 640x480 at 60 Hz, 800x525 total
`define H_RES     640      // visible pixels per line
`define V_RES     480      // visible lines per frame
`define H_TOTAL   800      // pixels per line incl. blanking
`define V_TOTAL   525      // lines per frame incl. blanking

// sync low while coord > STA and coord <= END
`define HS_STA    655      // hsync low from 656
`define HS_END    751      // 96 pixels wide
`define VS_STA    489      // vsync low from 490
`define VS_END    491      // 2 lines wide

// flag 16:10, top 400 lines, bounds exclusive
`define FLAG_H    400      // flag height in lines
`define CROSS_Y0  160      // horizontal bar above this
`define CROSS_Y1  240      // horizontal bar below this
`define CROSS_X0  200      // vertical bar right of this
`define CROSS_X1  280      // vertical bar left of this

`define CHW       4        // painter channel width

`endif

// ==== logic/flag_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster, colour and region types, flag palette constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "flag_defs.svh"

package flag_pkg;

    // position plus sync, 23 bits
    typedef struct packed {
        logic [`CORDW-1:0] sx;    // horizontal position
        logic [`CORDW-1:0] sy;    // vertical position
        logic              de;    // visible area
        logic              hsync; // active low
        logic              vsync; // active low
    } raster_t;

    // painter colour, one nibble per channel
    typedef struct packed {
        logic [`CHW-1:0] r;
        logic [`CHW-1:0] g;
        logic [`CHW-1:0] b;
    } colour_t;

    // output colour, 8 bits per channel
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } colour8_t;

    typedef enum logic [1:0] {
        REG_CROSS,   // yellow cross
        REG_FIELD,   // blue field
        REG_OUTSIDE  // below the flag
    } flag_region_e;

    // palette
    localparam colour_t PAL_CROSS   = '{r: 4'hF, g: 4'hC, b: 4'h0};
    localparam colour_t PAL_FIELD   = '{r: 4'h0, g: 4'h6, b: 4'hA};
    localparam colour_t PAL_OUTSIDE = '{r: 4'h0, g: 4'h0, b: 4'h0}; // doubles as blanking black

    // raster as seen while the pipeline is in reset, sync inactive
    localparam raster_t RASTER_RST = '{sx: '0, sy: '0, de: 1'b0, hsync: 1'b1, vsync: 1'b1};

endpackage

`default_nettype wire

// ==== logic/raster_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster position and sync bundle, generator and sink views
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "flag_defs.svh"

interface raster_if;

    logic [`CORDW-1:0] sx;    // horizontal position
    logic [`CORDW-1:0] sy;    // vertical position
    logic              de;    // high in visible area
    logic              hsync; // active low
    logic              vsync; // active low

    // timing generator side
    modport gen (
        output sx, sy, de, hsync, vsync
    );

    // consumers
    modport sink (
        input sx, sy, de, hsync, vsync
    );

endinterface

`default_nettype wire

// ==== logic/display_timing.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 800x525 raster counter, 640x480 visible, registered de and sync
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "flag_defs.svh"

module display_timing (
    input  logic   clk_pix,  // pixel clock
    input  logic   rst,      // sync reset, active high
    raster_if.gen  ras       // position and sync out
);

    localparam logic [`CORDW-1:0] H_LAST = `H_TOTAL - 1;  // 799
    localparam logic [`CORDW-1:0] V_LAST = `V_TOTAL - 1;  // 524
    localparam logic [`CORDW-1:0] H_VIS  = `H_RES;
    localparam logic [`CORDW-1:0] V_VIS  = `V_RES;
    localparam logic [`CORDW-1:0] HS_STA = `HS_STA;
    localparam logic [`CORDW-1:0] HS_END = `HS_END;
    localparam logic [`CORDW-1:0] VS_STA = `VS_STA;
    localparam logic [`CORDW-1:0] VS_END = `VS_END;

    logic [`CORDW-1:0] sx_q, sy_q;      // current position
    logic [`CORDW-1:0] sx_nxt, sy_nxt;  // position one cycle on
    logic              de_q, hsync_q, vsync_q;

    // step the counters, sy moves on the line wrap
    always_comb begin
        sx_nxt = sx_q + 1'b1;
        sy_nxt = sy_q;
        if (sx_q == H_LAST) begin
            sx_nxt = '0;
            sy_nxt = (sy_q == V_LAST) ? '0 : sy_q + 1'b1;  // frame wrap
        end
    end

    // flags come from the next position so they line up with sx_q/sy_q
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx_q    <= '0;
            sy_q    <= '0;
            de_q    <= 1'b1;  // (0,0) is visible
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            sx_q    <= sx_nxt;
            sy_q    <= sy_nxt;
            de_q    <= (sx_nxt < H_VIS) && (sy_nxt < V_VIS);
            hsync_q <= ~((sx_nxt > HS_STA) && (sx_nxt <= HS_END));  // low 656..751
            vsync_q <= ~((sy_nxt > VS_STA) && (sy_nxt <= VS_END));  // low 490..491
        end
    end

    assign ras.sx    = sx_q;
    assign ras.sy    = sy_q;
    assign ras.de    = de_q;
    assign ras.hsync = hsync_q;
    assign ras.vsync = vsync_q;

endmodule

`default_nettype wire

// ==== logic/pipe_delay.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed depth register pipeline, any payload type, reset to RST_VAL
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module pipe_delay #(
    parameter type         T       = flag_pkg::flag_region_e,  // payload
    parameter int unsigned DEPTH   = 1,                        // stages, at least 1
    parameter T            RST_VAL = T'('0)                    // value held in reset
) (
    input  logic clk_pix,  // pixel clock
    input  logic rst,      // sync reset, active high
    input  T     d,        // payload in
    output T     q         // payload DEPTH cycles later
);

    T stage_q [DEPTH];  // shift chain, [0] nearest the input

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= RST_VAL;
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];  // shift along
            end
        end
    end

    assign q = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== logic/flag_painter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag of sweden painter: region decode stage, then palette stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "flag_defs.svh"

module flag_painter (
    input  logic              clk_pix,  // pixel clock
    input  logic              rst,      // sync reset, active high
    raster_if.sink            ras,      // position from the generator
    output flag_pkg::colour_t colour    // two cycles after ras
);

    localparam logic [`CORDW-1:0] FLAG_H   = `FLAG_H;
    localparam logic [`CORDW-1:0] CROSS_Y0 = `CROSS_Y0;
    localparam logic [`CORDW-1:0] CROSS_Y1 = `CROSS_Y1;
    localparam logic [`CORDW-1:0] CROSS_X0 = `CROSS_X0;
    localparam logic [`CORDW-1:0] CROSS_X1 = `CROSS_X1;

    logic                   in_hbar;   // rows 161..239
    logic                   in_vbar;   // cols 201..279 on the flag
    logic                   in_flag;   // rows 0..399
    flag_pkg::flag_region_e region_d;
    flag_pkg::flag_region_e region_q;  // stage 1 result
    logic                   de_q;      // de lined up with region_q

    assign in_flag = ras.sy < FLAG_H;
    assign in_hbar = (ras.sy > CROSS_Y0) && (ras.sy < CROSS_Y1);
    assign in_vbar = in_flag && (ras.sx > CROSS_X0) && (ras.sx < CROSS_X1);

    // horizontal bar wins, then vertical bar, then field
    always_comb begin
        if (in_hbar) begin
            region_d = flag_pkg::REG_CROSS;
        end else if (in_vbar) begin
            region_d = flag_pkg::REG_CROSS;
        end else if (in_flag) begin
            region_d = flag_pkg::REG_FIELD;
        end else begin
            region_d = flag_pkg::REG_OUTSIDE;  // black below the flag
        end
    end

    // stage 1, classify
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            region_q <= flag_pkg::REG_OUTSIDE;
            de_q     <= 1'b0;
        end else begin
            region_q <= region_d;
            de_q     <= ras.de;
        end
    end

    // stage 2, palette lookup
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            colour <= '0;
        end else if (!de_q) begin
            colour <= flag_pkg::PAL_OUTSIDE;  // blanking is black
        end else begin
            case (region_q)
                flag_pkg::REG_CROSS: colour <= flag_pkg::PAL_CROSS;
                flag_pkg::REG_FIELD: colour <= flag_pkg::PAL_FIELD;
                default:             colour <= flag_pkg::PAL_OUTSIDE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_out_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output register: 4 to 8 bit colour widening plus aligned raster
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "flag_defs.svh"

module video_out_stage (
    input  logic              clk_pix,  // pixel clock
    input  logic              rst,      // sync reset, active high
    input  flag_pkg::raster_t ras_in,   // raster matching colour
    input  flag_pkg::colour_t colour,   // nibble per channel
    output logic [`CORDW-1:0] sx,       // horizontal position
    output logic [`CORDW-1:0] sy,       // vertical position
    output logic              de,       // visible area
    output logic              hsync,    // active low
    output logic              vsync,    // active low
    output logic [7:0]        r,        // 8-bit red
    output logic [7:0]        g,        // 8-bit green
    output logic [7:0]        b         // 8-bit blue
);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= flag_pkg::RASTER_RST.sx;
            sy    <= flag_pkg::RASTER_RST.sy;
            de    <= flag_pkg::RASTER_RST.de;     // blanked
            hsync <= flag_pkg::RASTER_RST.hsync;  // inactive
            vsync <= flag_pkg::RASTER_RST.vsync;
            r     <= '0;
            g     <= '0;
            b     <= '0;
        end else begin
            sx    <= ras_in.sx;
            sy    <= ras_in.sy;
            de    <= ras_in.de;
            hsync <= ras_in.hsync;
            vsync <= ras_in.vsync;
            r     <= {2{colour.r}};  // F -> FF, A -> AA
            g     <= {2{colour.g}};
            b     <= {2{colour.b}};
        end
    end

endmodule

`default_nettype wire

// ==== logic/flag_sweden_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag of sweden display top: timing, painter, raster delay, output stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "flag_defs.svh"

module flag_sweden_top (
    input  logic              clk_pix,  // pixel clock
    input  logic              rst,      // sync reset, active high
    output logic [`CORDW-1:0] sx,       // horizontal position
    output logic [`CORDW-1:0] sy,       // vertical position
    output logic              de,       // visible area
    output logic              hsync,    // active low
    output logic              vsync,    // active low
    output logic [7:0]        r,        // 8-bit red
    output logic [7:0]        g,        // 8-bit green
    output logic [7:0]        b         // 8-bit blue
);

    raster_if ras ();                // generator output

    flag_pkg::raster_t ras_now;      // packed generator raster
    flag_pkg::raster_t ras_dly;      // aligned with painter colour
    flag_pkg::colour_t paint_colour; // two cycles behind ras

    display_timing i_display_timing (
        .clk_pix,
        .rst,
        .ras (ras.gen)
    );

    flag_painter i_flag_painter (
        .clk_pix,
        .rst,
        .ras    (ras.sink),
        .colour (paint_colour)
    );

    assign ras_now = '{sx: ras.sx, sy: ras.sy, de: ras.de, hsync: ras.hsync, vsync: ras.vsync};

    // two stages, same as the painter
    pipe_delay #(
        .T       (flag_pkg::raster_t),
        .DEPTH   (2),
        .RST_VAL (flag_pkg::RASTER_RST)  // sync inactive in reset
    ) i_raster_delay (
        .clk_pix,
        .rst,
        .d (ras_now),
        .q (ras_dly)
    );

    video_out_stage i_video_out_stage (
        .clk_pix,
        .rst,
        .ras_in (ras_dly),
        .colour (paint_colour),
        .sx,
        .sy,
        .de,
        .hsync,
        .vsync,
        .r,
        .g,
        .b
    );

endmodule

`default_nettype wire

// ==== tb/flag_sweden_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound checks on the flag display ports: sync widths, de, coordinate steps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "flag_defs.svh"

module flag_sweden_chk (
    input logic              clk_pix,  // pixel clock
    input logic              rst,      // sync reset, active high
    input logic [`CORDW-1:0] sx,
    input logic [`CORDW-1:0] sy,
    input logic              de,
    input logic              hsync,    // active low
    input logic              vsync     // active low
);

    localparam logic [`CORDW-1:0] H_LAST   = `H_TOTAL - 1;
    localparam logic [`CORDW-1:0] V_LAST   = `V_TOTAL - 1;
    localparam int unsigned       HS_WIDTH = `HS_END - `HS_STA;               // 96 pixels
    localparam int unsigned       VS_WIDTH = (`VS_END - `VS_STA) * `H_TOTAL;  // 2 lines

    logic [2:0]  settle_cnt;  // edges since release, stops at 4
    int unsigned hs_low_cnt;  // cycles of the current hsync pulse
    int unsigned vs_low_cnt;

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            settle_cnt <= '0;
            hs_low_cnt <= 0;
            vs_low_cnt <= 0;
        end else begin
            if (settle_cnt != 3'd4) settle_cnt <= settle_cnt + 1'b1;
            hs_low_cnt <= hsync ? 0 : hs_low_cnt + 1;
            vs_low_cnt <= vsync ? 0 : vs_low_cnt + 1;
        end
    end

    hsync_width: assert property (@(posedge clk_pix) disable iff (rst)
        $rose(hsync) |-> hs_low_cnt == HS_WIDTH)
        else $error("hsync pulse was %0d pixels", hs_low_cnt);

    vsync_width: assert property (@(posedge clk_pix) disable iff (rst)
        $rose(vsync) |-> vs_low_cnt == VS_WIDTH)
        else $error("vsync pulse was %0d cycles", vs_low_cnt);

    // pipeline holds idle values for three cycles after release
    de_area: assert property (@(posedge clk_pix) disable iff (rst)
        settle_cnt >= 3'd3 |-> de == ((sx < `H_RES) && (sy < `V_RES)))
        else $error("de wrong at (%0d,%0d)", sx, sy);

    sx_step: assert property (@(posedge clk_pix) disable iff (rst)
        settle_cnt == 3'd4 |-> sx == (($past(sx) == H_LAST) ? '0 : $past(sx) + 1'b1))
        else $error("sx stepped to %0d", sx);

    sy_step: assert property (@(posedge clk_pix) disable iff (rst)
        settle_cnt == 3'd4 |->
            sy == (($past(sx) != H_LAST) ? $past(sy) :
                   ($past(sy) == V_LAST) ? '0 : $past(sy) + 1'b1))
        else $error("sy stepped to %0d", sy);

endmodule

`default_nettype wire

// ==== tb/flag_sweden_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag display testbench: reset checks, probe table, full frame sweep,
// random visible pixels, colour and raster compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "flag_defs.svh"

module flag_sweden_tb;

    localparam int TIMEOUT_CYCLES = 500000;               // a bit over one frame
    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;  // 420000
    localparam int N_PROBES       = 18;
    localparam int N_RANDOM       = 12;

    // each nibble doubled to 8 bits
    localparam flag_pkg::colour8_t YELLOW = 24'hFF_CC_00;  // cross F,C,0
    localparam flag_pkg::colour8_t BLUE   = 24'h00_66_AA;  // field 0,6,A
    localparam flag_pkg::colour8_t BLACK  = 24'h00_00_00;
    localparam flag_pkg::raster_t  IDLE_RASTER =
        '{sx: '0, sy: '0, de: 1'b0, hsync: 1'b1, vsync: 1'b1};

    typedef struct packed {
        logic [`CORDW-1:0]  x;
        logic [`CORDW-1:0]  y;
        flag_pkg::colour8_t colour;
    } probe_t;

    // probe pixels in scan order within one frame
    localparam probe_t PROBES [N_PROBES] = '{
        '{10'd10,  10'd5,   BLUE},    // top left field
        '{10'd700, 10'd10,  BLACK},   // horizontal blanking
        '{10'd200, 10'd100, BLUE},    // vbar bound is exclusive
        '{10'd201, 10'd100, YELLOW},  // first vbar column
        '{10'd279, 10'd100, YELLOW},  // last vbar column
        '{10'd280, 10'd100, BLUE},
        '{10'd500, 10'd160, BLUE},    // hbar bound is exclusive
        '{10'd500, 10'd161, YELLOW},  // first hbar row
        '{10'd240, 10'd200, YELLOW},  // cross centre
        '{10'd639, 10'd239, YELLOW},  // last hbar row, right edge
        '{10'd100, 10'd240, BLUE},
        '{10'd250, 10'd300, YELLOW},  // vbar below the hbar
        '{10'd600, 10'd300, BLUE},
        '{10'd100, 10'd399, BLUE},
        '{10'd250, 10'd399, YELLOW},  // bottom row of the flag
        '{10'd250, 10'd400, BLACK},   // below the flag
        '{10'd639, 10'd479, BLACK},   // last visible pixel
        '{10'd320, 10'd480, BLACK}    // vertical blanking
    };

    logic              clk_pix;
    logic              rst;
    logic [`CORDW-1:0] sx, sy;
    logic              de, hsync, vsync;
    logic [7:0]        r, g, b;
    int                rand_keys [$];  // y*H_TOTAL+x, sorted into scan order

    flag_sweden_top i_flag_sweden_top (
        .clk_pix, .rst, .sx, .sy, .de, .hsync, .vsync, .r, .g, .b
    );

    bind flag_sweden_top flag_sweden_chk i_flag_sweden_chk (
        .clk_pix, .rst, .sx, .sy, .de, .hsync, .vsync
    );

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;  // 50 MHz, 20 ns
    end

    // geometry rule: hbar first, then vbar on the flag, then field
    function automatic flag_pkg::colour8_t expected_colour(input int x, input int y);
        logic visible, on_flag, hbar, vbar;
        visible = (x < `H_RES) && (y < `V_RES);
        on_flag = y < `FLAG_H;
        hbar    = (y > `CROSS_Y0) && (y < `CROSS_Y1);
        vbar    = on_flag && (x > `CROSS_X0) && (x < `CROSS_X1);
        if (!visible || !on_flag) return BLACK;
        if (hbar || vbar) return YELLOW;
        return BLUE;
    endfunction

    function automatic flag_pkg::raster_t expected_raster(input int x, input int y);
        flag_pkg::raster_t ras;
        ras.sx    = x[`CORDW-1:0];
        ras.sy    = y[`CORDW-1:0];
        ras.de    = (x < `H_RES) && (y < `V_RES);
        ras.hsync = !(x inside {[`HS_STA + 1 : `HS_END]});  // low 656..751
        ras.vsync = !(y inside {[`VS_STA + 1 : `VS_END]});  // low 490..491
        return ras;
    endfunction

    function automatic flag_pkg::raster_t port_raster();
        return '{sx: sx, sy: sy, de: de, hsync: hsync, vsync: vsync};
    endfunction

    function automatic flag_pkg::colour8_t port_colour();
        return '{r: r, g: g, b: b};
    endfunction

    function automatic string raster_text(input flag_pkg::raster_t ras);
        return $sformatf("(%0d,%0d) de=%b hs=%b vs=%b", ras.sx, ras.sy, ras.de, ras.hsync,
                         ras.vsync);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_colour(input string name, input flag_pkg::colour8_t exp,
                                input flag_pkg::colour8_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected rgb %h, actual rgb %h", name, exp, act));
        end
    endtask

    task automatic check_raster(input string name, input flag_pkg::raster_t exp,
                                input flag_pkg::raster_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %s, actual %s", name,
                                raster_text(exp), raster_text(act)));
        end
    endtask

    // outputs sampled and inputs driven 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk_pix);
        #1;
    endtask

    task automatic wait_for_pixel(input int x, input int y);
        bit found;
        found = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES && !found; n++) begin
            next_cycle();
            found = (int'(sx) == x) && (int'(sy) == y);
        end
        if (!found) begin
            abort_run($sformatf("timeout: pixel (%0d,%0d) never appeared on the output ports",
                                x, y));
        end
    endtask

    initial begin
        int    x, y;
        string name;
        rst = 1'b1;
        void'($urandom(78139));

        // reset held 5 cycles, outputs idle throughout
        for (int i = 0; i < 5; i++) begin
            next_cycle();
            check_raster("reset", IDLE_RASTER, port_raster());
            check_colour("reset", BLACK, port_colour());
        end
        rst = 1'b0;
        next_cycle();
        check_raster("first cycle after reset", IDLE_RASTER, port_raster());
        check_colour("first cycle after reset", BLACK, port_colour());

        for (int i = 0; i < N_PROBES; i++) begin
            x = int'(PROBES[i].x);
            y = int'(PROBES[i].y);
            name = $sformatf("probe %0d (%0d,%0d)", i, x, y);
            wait_for_pixel(x, y);
            check_raster(name, expected_raster(x, y), port_raster());
            check_colour(name, PROBES[i].colour, port_colour());
        end

        // every pixel of one frame, stepping by the scan rule
        wait_for_pixel(0, 0);
        x = 0;
        y = 0;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            name = $sformatf("sweep (%0d,%0d)", x, y);
            check_raster(name, expected_raster(x, y), port_raster());
            check_colour(name, expected_colour(x, y), port_colour());
            x++;
            if (x == `H_TOTAL) begin
                x = 0;
                y = (y == `V_TOTAL - 1) ? 0 : y + 1;  // frame wrap
            end
            next_cycle();
        end
        check_raster("frame wrap", expected_raster(0, 0), port_raster());

        // random visible pixels, sorted so one frame covers them
        for (int i = 0; i < N_RANDOM; i++) begin
            x = int'($urandom_range(`H_RES - 1, 0));
            y = int'($urandom_range(`V_RES - 1, 0));
            rand_keys.push_back(y * `H_TOTAL + x);
        end
        rand_keys.sort();
        foreach (rand_keys[i]) begin
            x = rand_keys[i] % `H_TOTAL;
            y = rand_keys[i] / `H_TOTAL;
            name = $sformatf("random (%0d,%0d)", x, y);
            wait_for_pixel(x, y);
            check_colour(name, expected_colour(x, y), port_colour());
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/flag_pkg.sv
logic/raster_if.sv
logic/display_timing.sv
logic/pipe_delay.sv
logic/flag_painter.sv
logic/video_out_stage.sv
logic/flag_sweden_top.sv
tb/flag_sweden_chk.sv
tb/flag_sweden_tb.sv

// ==== Makefile ====
# Verilator build and run of the flag display testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module flag_sweden_tb -f files.f -o sim_flag
	./obj_dir/sim_flag | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
